//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= tbSingleCycleMips
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

# the simulator exits non-zero on $fatal, so make fails with it
run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
  input  var mipsPkg::instrWord instr,
  input  wire  [1:0]            aluClass,
  input  wire                   aluSrc,
  input  wire  [31:0]           readData1,
  input  wire  [31:0]           readData2,
  output logic [31:0]           aluResult,
  output logic                  aluZero
);

  // selected operation
  logic [3:0]  aluOp;
  // sign-extended offset
  logic [31:0] immExt;
  // second operand
  logic [31:0] operandB;

  // ============================================================
  // operation select
  // ============================================================
  always_comb begin
    case (aluClass)
      mipsPkg::clsMemAdd: begin
        aluOp = mipsPkg::aluAdd;
      end
      mipsPkg::clsBranchSub: begin
        aluOp = mipsPkg::aluSub;
      end
      mipsPkg::clsFunct: begin
        // r-type picks by funct
        case (instr.r.funct)
          mipsPkg::fnAdd: aluOp = mipsPkg::aluAdd;
          mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
          mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
          mipsPkg::fnOr:  aluOp = mipsPkg::aluOr;
          mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
          default:        aluOp = mipsPkg::aluNone;
        endcase
      end
      default: begin
        aluOp = mipsPkg::aluNone;
      end
    endcase
  end

  // ============================================================
  // operand path
  // ============================================================
  // replicate bit 15 into the upper half
  assign immExt   = {{16{instr.i.imm[15]}}, instr.i.imm};
  assign operandB = aluSrc ? immExt : readData2;

  // ============================================================
  // arithmetic and logic
  // ============================================================
  always_comb begin
    case (aluOp)
      mipsPkg::aluAdd: aluResult = readData1 + operandB;
      mipsPkg::aluSub: aluResult = readData1 - operandB;
      mipsPkg::aluAnd: aluResult = readData1 & operandB;
      mipsPkg::aluOr:  aluResult = readData1 | operandB;
      // unsigned compare
      mipsPkg::aluSlt: aluResult = (readData1 < operandB) ? 32'd1 : 32'd0;
      default:         aluResult = 32'd0;
    endcase
  end

  // zero flag for subtract only
  assign aluZero = (aluOp == mipsPkg::aluSub) && (aluResult == 32'd0);

endmodule

`default_nettype wire

//--- hdl/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
  input  var mipsPkg::instrWord instr,
  output logic                  regDst,
  output logic                  aluSrc,
  output logic                  memToReg,
  output logic                  regWrite,
  output logic                  branch,
  output logic                  jump,
  output logic                  link,
  output logic                  jumpReg,
  output logic                  cen,
  output logic                  wen,
  output logic [1:0]            aluClass
);

  // ============================================================
  // field decode
  // ============================================================
  logic [5:0] opcode;
  logic [5:0] funct;

  // per-instruction flags
  logic isRType;
  logic isLw;
  logic isSw;
  logic isBeq;
  logic isJ;
  logic isJal;
  logic isJr;

  // opcode and funct through the r view
  assign opcode = instr.r.opcode;
  assign funct  = instr.r.funct;

  assign isRType = (opcode == mipsPkg::opRType);
  assign isLw    = (opcode == mipsPkg::opLw);
  assign isSw    = (opcode == mipsPkg::opSw);
  assign isBeq   = (opcode == mipsPkg::opBeq);
  assign isJ     = (opcode == mipsPkg::opJ);
  assign isJal   = (opcode == mipsPkg::opJal);
  // jr lives in the r-type space
  assign isJr    = isRType && (funct == mipsPkg::fnJr);

  // ============================================================
  // datapath controls
  // ============================================================
  // rd destination only for r-type
  assign regDst   = isRType;
  // immediate operand for everything except r-type and beq
  assign aluSrc   = !isRType && !isBeq;
  assign memToReg = isLw;
  // no write back for stores, branches and jumps without link
  assign regWrite = !(isSw || isBeq || isJ || isJr);
  assign branch   = isBeq;
  assign jump     = isJ || isJal;
  assign link     = isJal;
  assign jumpReg  = isJr;

  // alu class select
  always_comb begin
    if (isRType) begin
      aluClass = mipsPkg::clsFunct;
    end else if (isBeq) begin
      aluClass = mipsPkg::clsBranchSub;
    end else begin
      aluClass = mipsPkg::clsMemAdd;
    end
  end

  // ============================================================
  // data memory strobes
  // ============================================================
  // chip enable low on any memory access
  assign cen = !(isLw || isSw);
  // write enable low on stores only
  assign wen = !isSw;

endmodule

`default_nettype wire

//--- hdl/mipsPkg.sv
`default_nettype none

package mipsPkg;

  // ============================================================
  // opcode field values
  // ============================================================
  // r-type shares one opcode and uses funct
  localparam logic [5:0] opRType = 6'b000000;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;
  localparam logic [5:0] opBeq   = 6'b000100;
  localparam logic [5:0] opJ     = 6'b000010;
  localparam logic [5:0] opJal   = 6'b000011;

  // ============================================================
  // funct field values for r-type
  // ============================================================
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;
  localparam logic [5:0] fnJr  = 6'b001000;

  // ============================================================
  // alu operation codes
  // ============================================================
  localparam logic [3:0] aluAnd  = 4'b0000;
  localparam logic [3:0] aluOr   = 4'b0001;
  localparam logic [3:0] aluAdd  = 4'b0010;
  localparam logic [3:0] aluSub  = 4'b0110;
  localparam logic [3:0] aluSlt  = 4'b0111;
  // result forced to zero
  localparam logic [3:0] aluNone = 4'b1111;

  // alu class from the decoder
  localparam logic [1:0] clsMemAdd    = 2'b00;
  localparam logic [1:0] clsBranchSub = 2'b01;
  localparam logic [1:0] clsFunct     = 2'b10;

  // jal link destination
  localparam logic [4:0] regLink = 5'd31;

  // word address width of the data memory port
  localparam int dataAddrWidth = 7;

  // one instruction word seen as r, i or j form
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] target;
    } j;
  } instrWord;

endpackage

`default_nettype wire

//--- hdl/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   branch,
  input  wire                   jump,
  input  wire                   jumpReg,
  input  wire                   aluZero,
  input  var mipsPkg::instrWord instr,
  input  wire  [31:0]           readData1,
  output logic [31:0]           pc,
  output logic [31:0]           pcPlus4
);

  // candidate targets
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic [31:0] pcNext;
  // beq condition met
  logic        branchTaken;

  // ============================================================
  // target computation
  // ============================================================
  assign pcPlus4 = pc + 32'd4;

  // word offset relative to the next instruction
  assign branchTarget = pcPlus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};

  // stays inside the current 256MB region
  assign jumpTarget = {pcPlus4[31:28], instr.j.target, 2'b00};

  assign branchTaken = branch && aluZero;

  // jump then branch then jr then sequential
  always_comb begin
    if (jump) begin
      pcNext = jumpTarget;
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else if (jumpReg) begin
      pcNext = readData1;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // ============================================================
  // pc register
  // ============================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= 32'd0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

//--- hdl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   regWrite,
  input  wire                   regDst,
  input  wire                   memToReg,
  input  wire                   link,
  input  var mipsPkg::instrWord instr,
  input  wire  [31:0]           aluResult,
  input  wire  [31:0]           memReadData,
  input  wire  [31:0]           pcPlus4,
  output logic [31:0]           readData1,
  output logic [31:0]           readData2,
  output logic [31:0]           writeData
);

  // register array
  logic [31:0] regs [32];

  // write destination
  logic [4:0] writeAddr;

  // ============================================================
  // read ports
  // ============================================================
  // r0 reads as zero regardless of contents
  assign readData1 = (instr.r.rs == 5'd0) ? 32'd0 : regs[instr.r.rs];
  assign readData2 = (instr.r.rt == 5'd0) ? 32'd0 : regs[instr.r.rt];

  // ============================================================
  // write select
  // ============================================================
  // link overrides both rd and rt
  always_comb begin
    if (link) begin
      writeAddr = mipsPkg::regLink;
    end else if (regDst) begin
      writeAddr = instr.r.rd;
    end else begin
      writeAddr = instr.r.rt;
    end
  end

  // return address wins over load and alu data
  always_comb begin
    if (link) begin
      writeData = pcPlus4;
    end else if (memToReg) begin
      writeData = memReadData;
    end else begin
      writeData = aluResult;
    end
  end

  // ============================================================
  // write port
  // ============================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int idx = 0; idx < 32; idx++) begin
        regs[idx] <= 32'd0;
      end
    end else if (regWrite && (writeAddr != 5'd0)) begin
      // r0 never written
      regs[writeAddr] <= writeData;
    end
  end

endmodule

`default_nettype wire

//--- hdl/singleCycleMips.sv
`timescale 1ns/1ps
`default_nettype none

module singleCycleMips (
  input  wire                               clk,
  input  wire                               rst,
  input  wire  [31:0]                       instr,
  input  wire  [31:0]                       memReadData,
  output logic [31:0]                       instrAddr,
  output logic [31:0]                       rfWriteData,
  output logic [31:0]                       memWriteData,
  output logic [mipsPkg::dataAddrWidth-1:0] memAddr,
  output logic                              cen,
  output logic                              wen
);

  // ============================================================
  // internal nets
  // ============================================================
  // fetched word in union form
  mipsPkg::instrWord instrDec;

  // decoder controls
  logic       regDst;
  logic       aluSrc;
  logic       memToReg;
  logic       regWrite;
  logic       branch;
  logic       jump;
  logic       link;
  logic       jumpReg;
  logic [1:0] aluClass;

  // datapath values
  logic [31:0] readData1;
  logic [31:0] readData2;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [31:0] pc;
  logic [31:0] pcPlus4;

  assign instrDec = mipsPkg::instrWord'(instr);

  // ============================================================
  // decode
  // ============================================================
  controlDecoder controlDecoder_i (
    .instr    (instrDec),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .regWrite (regWrite),
    .branch   (branch),
    .jump     (jump),
    .link     (link),
    .jumpReg  (jumpReg),
    .cen      (cen),
    .wen      (wen),
    .aluClass (aluClass)
  );

  // register read and write back
  registerFile registerFile_i (
    .clk         (clk),
    .rst         (rst),
    .regWrite    (regWrite),
    .regDst      (regDst),
    .memToReg    (memToReg),
    .link        (link),
    .instr       (instrDec),
    .aluResult   (aluResult),
    .memReadData (memReadData),
    .pcPlus4     (pcPlus4),
    .readData1   (readData1),
    .readData2   (readData2),
    .writeData   (rfWriteData)
  );

  // ============================================================
  // execute
  // ============================================================
  aluUnit aluUnit_i (
    .instr     (instrDec),
    .aluClass  (aluClass),
    .aluSrc    (aluSrc),
    .readData1 (readData1),
    .readData2 (readData2),
    .aluResult (aluResult),
    .aluZero   (aluZero)
  );

  // next fetch address
  programCounter programCounter_i (
    .clk       (clk),
    .rst       (rst),
    .branch    (branch),
    .jump      (jump),
    .jumpReg   (jumpReg),
    .aluZero   (aluZero),
    .instr     (instrDec),
    .readData1 (readData1),
    .pc        (pc),
    .pcPlus4   (pcPlus4)
  );

  // ============================================================
  // external ports
  // ============================================================
  assign instrAddr    = pc;
  // store data comes straight from rt
  assign memWriteData = readData2;
  // byte address to word address
  assign memAddr      = aluResult[mipsPkg::dataAddrWidth+1:2];

endmodule

`default_nettype wire

//--- sources.f
hdl/mipsPkg.sv
hdl/controlDecoder.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/programCounter.sv
hdl/singleCycleMips.sv
testbench/tbSingleCycleMips.sv

//--- testbench/tbSingleCycleMips.sv
`timescale 1ns/1ps
`default_nettype none

module tbSingleCycleMips;

  // ============================================================
  // constants
  // ============================================================
  localparam int          romDepth    = 64;
  localparam int          resetCycles = 8;
  localparam time         driveDelay  = 2;
  localparam time         sampleDelay = 5;
  localparam logic [31:0] lcgSeed     = 32'h3fd5;
  // add r0, r0, r0
  localparam logic [31:0] nopWord = {mipsPkg::opRType, 20'd0, mipsPkg::fnAdd};

  // dut ports
  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] fetchWord;
  logic [31:0] memReadData;
  logic [31:0] instrAddr;
  logic [31:0] rfWriteData;
  logic [31:0] memWriteData;
  logic [mipsPkg::dataAddrWidth-1:0] memAddr;
  logic        cen;
  logic        wen;

  // stimulus table by word address
  logic [31:0] romInstr  [romDepth];
  logic        chkWd     [romDepth];
  logic [31:0] expWd     [romDepth];
  logic [31:0] expNext   [romDepth];
  logic        storeRow  [romDepth];
  logic [6:0]  storeAddr [romDepth];
  logic [31:0] storeData [romDepth];
  int          rowCount = 0;

  // data memory and its reference copy
  logic [31:0] dataMem   [128];
  logic [31:0] shadowMem [128];
  logic [31:0] romIndex;
  int          cycleCount = 0;

  always #10 clk = ~clk;

  singleCycleMips singleCycleMips_i (
    .clk          (clk),
    .rst          (rst),
    .instr        (fetchWord),
    .memReadData  (memReadData),
    .instrAddr    (instrAddr),
    .rfWriteData  (rfWriteData),
    .memWriteData (memWriteData),
    .memAddr      (memAddr),
    .cen          (cen),
    .wen          (wen)
  );

  // ============================================================
  // helpers
  // ============================================================
  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // addr-th step of the sequence from the seed
  function automatic logic [31:0] preloadWord(input int addr);
    logic [31:0] state;
    state = lcgSeed;
    for (int k = 0; k <= addr; k++) begin
      state = nextRandom(state);
    end
    return state;
  endfunction

  function automatic logic [31:0] rTypeWord(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [5:0] funct);
    return {mipsPkg::opRType, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] iTypeWord(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jTypeWord(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic addRow(input logic [31:0] word, input logic check,
                        input logic [31:0] wd, input logic [31:0] nextAddr);
    romInstr[rowCount] = word;
    chkWd[rowCount]    = check;
    expWd[rowCount]    = wd;
    expNext[rowCount]  = nextAddr;
    rowCount++;
  endtask

  // store expectation for the last row and its memory copy
  task automatic expectStore(input logic [6:0] addr, input logic [31:0] data);
    storeRow[rowCount-1]  = 1'b1;
    storeAddr[rowCount-1] = addr;
    storeData[rowCount-1] = data;
    shadowMem[addr]       = data;
  endtask

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("Fail at %0t: %s, got %h expected %h", $time, what, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // ============================================================
  // memory models
  // ============================================================
  assign romIndex  = {2'b00, instrAddr[31:2]};
  assign fetchWord = (romIndex < 32'(romDepth)) ? romInstr[romIndex[5:0]] : nopWord;

  // combinational read and edge write when both strobes are low
  assign memReadData = cen ? 32'd0 : dataMem[memAddr];

  always @(posedge clk) begin
    if (!rst) begin
      for (int a = 0; a < 128; a++) begin
        dataMem[a] <= preloadWord(a);
      end
    end else if (!cen && !wen) begin
      dataMem[memAddr] <= memWriteData;
    end
  end

  // run limit from table length
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > 2 * rowCount + resetCycles) begin
      $display("Timeout: end of program not reached after %0d cycles", cycleCount);
      $display("Simulation FAILED");
      $fatal(1, "run aborted on timeout");
    end
  end

  // ============================================================
  // program table and stepping loop
  // ============================================================
  initial begin
    logic [31:0] valA;
    logic [31:0] valB;
    logic [31:0] storeByte;
    logic [6:0]  storeWord;
    logic [31:0] expAddr;
    logic [31:0] endAddr;
    logic [5:0]  op;
    logic        isMem;
    int          idx;

    // async clear of pc and registers
    rst = 1'b0;
    for (int a = 0; a < romDepth; a++) begin
      romInstr[a] = nopWord;
      storeRow[a] = 1'b0;
    end
    for (int a = 0; a < 128; a++) begin
      shadowMem[a] = preloadWord(a);
    end
    valA = shadowMem[4];
    valB = shadowMem[5];

    // reset no-op and then a read of unwritten registers
    addRow(nopWord, 1'b1, 32'd0, 32'd4);
    addRow(rTypeWord(5'd7, 5'd9, 5'd5, mipsPkg::fnAdd), 1'b1, 32'd0, 32'd8);
    // operands from preloaded words 4 and 5
    addRow(iTypeWord(mipsPkg::opLw, 5'd0, 5'd1, 16'd16), 1'b1, valA, 32'd12);
    addRow(iTypeWord(mipsPkg::opLw, 5'd0, 5'd2, 16'd20), 1'b1, valB, 32'd16);
    addRow(iTypeWord(mipsPkg::opLw, 5'd0, 5'd3, 16'd16), 1'b1, valA, 32'd20);
    // r-type group
    addRow(rTypeWord(5'd1, 5'd2, 5'd4, mipsPkg::fnAdd), 1'b1, valA + valB, 32'd24);
    addRow(rTypeWord(5'd1, 5'd2, 5'd5, mipsPkg::fnSub), 1'b1, valA - valB, 32'd28);
    addRow(rTypeWord(5'd1, 5'd2, 5'd6, mipsPkg::fnAnd), 1'b1, valA & valB, 32'd32);
    addRow(rTypeWord(5'd1, 5'd2, 5'd7, mipsPkg::fnOr), 1'b1, valA | valB, 32'd36);
    // slt on equal operands and both orders
    addRow(rTypeWord(5'd1, 5'd3, 5'd8, mipsPkg::fnSlt), 1'b1, 32'd0, 32'd40);
    addRow(rTypeWord(5'd1, 5'd2, 5'd9, mipsPkg::fnSlt), 1'b1,
           (valA < valB) ? 32'd1 : 32'd0, 32'd44);
    addRow(rTypeWord(5'd2, 5'd1, 5'd10, mipsPkg::fnSlt), 1'b1,
           (valB < valA) ? 32'd1 : 32'd0, 32'd48);
    // store r4 at r1 + 8 and read it back
    storeByte = valA + 32'd8;
    storeWord = storeByte[8:2];
    addRow(iTypeWord(mipsPkg::opSw, 5'd1, 5'd4, 16'd8), 1'b1, storeByte, 32'd52);
    expectStore(storeWord, valA + valB);
    addRow(iTypeWord(mipsPkg::opLw, 5'd1, 5'd12, 16'd8), 1'b1, shadowMem[storeWord], 32'd56);
    addRow(iTypeWord(mipsPkg::opLw, 5'd0, 5'd13, 16'd100), 1'b1, shadowMem[25], 32'd60);
    // r0 write shows value but is dropped
    addRow(rTypeWord(5'd1, 5'd2, 5'd0, mipsPkg::fnAdd), 1'b1, valA + valB, 32'd64);
    addRow(rTypeWord(5'd0, 5'd2, 5'd14, mipsPkg::fnAdd), 1'b1, valB, 32'd68);
    // beq taken skips two words
    addRow(iTypeWord(mipsPkg::opBeq, 5'd1, 5'd3, 16'd2), 1'b1, 32'd0, 32'd80);
    addRow(nopWord, 1'b0, 32'd0, 32'hffff_fffc);
    addRow(nopWord, 1'b0, 32'd0, 32'hffff_fffc);
    addRow(iTypeWord(mipsPkg::opBeq, 5'd1, 5'd2, 16'd5), 1'b1, valA - valB, 32'd84);
    // jal to word 26 leaves 88 as link
    addRow(jTypeWord(mipsPkg::opJal, 26'd26), 1'b1, 32'd88, 32'd104);
    // return point
    addRow(rTypeWord(5'd31, 5'd0, 5'd15, mipsPkg::fnAdd), 1'b1, 32'd88, 32'd92);
    addRow(jTypeWord(mipsPkg::opJ, 26'd28), 1'b0, 32'd0, 32'd112);
    addRow(nopWord, 1'b0, 32'd0, 32'hffff_fffc);
    addRow(nopWord, 1'b0, 32'd0, 32'hffff_fffc);
    // subroutine
    addRow(rTypeWord(5'd31, 5'd0, 5'd16, mipsPkg::fnAdd), 1'b1, 32'd88, 32'd108);
    addRow(rTypeWord(5'd31, 5'd0, 5'd0, mipsPkg::fnJr), 1'b0, 32'd0, 32'd88);
    // last row sums both link copies
    addRow(rTypeWord(5'd15, 5'd16, 5'd17, mipsPkg::fnAdd), 1'b1, 32'd176, 32'd116);
    endAddr = 32'd116;

    repeat (resetCycles) @(posedge clk);
    #driveDelay rst = 1'b1;
    #(sampleDelay - driveDelay);

    // follow the executed path through the table
    expAddr = 32'd0;
    while (expAddr != endAddr) begin
      checkValue(instrAddr, expAddr, "fetch address");
      idx   = int'(expAddr[31:2]);
      op    = romInstr[idx][31:26];
      isMem = (op == mipsPkg::opLw) || (op == mipsPkg::opSw);
      if (chkWd[idx]) begin
        checkValue(rfWriteData, expWd[idx], "register write data");
      end
      checkValue(32'(cen), 32'(!isMem), "chip enable");
      checkValue(32'(wen), 32'(op != mipsPkg::opSw), "write enable");
      if (storeRow[idx]) begin
        checkValue(32'(memAddr), 32'(storeAddr[idx]), "store address");
        checkValue(memWriteData, storeData[idx], "store data");
      end
      expAddr = expNext[idx];
      @(posedge clk);
      #sampleDelay;
    end
    checkValue(instrAddr, endAddr, "final fetch address");

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
